// File: verilog.f
common/harness_pkg.sv
rtl/addr_decode.sv
mem/boot_rom.sv
mem/sram_bank.sv
rtl/resp_mux.sv
rtl/debug_gate.sv
rtl/harness_top.sv
tb/harness_properties.sv
tb/harness_tb.sv

// File: tb/harness_tb.sv
/*
 * Harness testbench
 * Drives ROM, SRAM, error and back-to-back accesses plus the debug gate,
 * checking every response against a reference memory model.
 */
`timescale 1ns/1ps

module harness_tb import harness_pkg::*;;

  localparam int unsigned SRAM_WORDS    = 256;
  localparam int unsigned DEBUG_HOLDOFF = 20;
  localparam int          CLK_PERIOD    = 4;
  localparam int          SRAM_TESTS    = 10;
  localparam int          TEST_CYCLES   = 8 + DEBUG_HOLDOFF + 16 + ROM_WORDS
                                          + 4 * SRAM_TESTS + 6 + 9 + 5 * 4;
  localparam int          TIMEOUT_NS    = (2 * TEST_CYCLES + 50) * CLK_PERIOD;

  typedef struct packed {
    bus_rsp_t    rsp;
    logic [31:0] due;
  } exp_t;

  logic        clk_i;
  logic        rst_ni;
  logic        req_valid_i;
  bus_req_t    req_i;
  logic        resp_valid_o;
  bus_rsp_t    resp_o;
  logic        debug_req_i;
  logic        debug_en_i;
  logic        debug_req_o;

  logic [DATA_W-1:0] ref_sram [SRAM_WORDS];
  exp_t              exp_q [$];
  exp_t              head;
  int unsigned       cyc;
  int unsigned       errors;
  int unsigned       tests_done;
  logic [31:0]       lcg_state;

  harness_top #(
    .SRAM_WORDS    ( SRAM_WORDS    ),
    .DEBUG_HOLDOFF ( DEBUG_HOLDOFF )
  ) uut (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_valid_i  ( req_valid_i  ),
    .req_i        ( req_i        ),
    .resp_valid_o ( resp_valid_o ),
    .resp_o       ( resp_o       ),
    .debug_req_i  ( debug_req_i  ),
    .debug_en_i   ( debug_en_i   ),
    .debug_req_o  ( debug_req_o  )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int unsigned total_errors();
    return errors + uut.i_harness_properties.prop_errors;
  endfunction

  // reference model of the address map
  function automatic bus_rsp_t model_access(bus_req_t req);
    bus_rsp_t    rsp;
    int unsigned idx;
    rsp = '{rdata: '0, err: 1'b0};
    if (req.addr >= ROM_BASE && req.addr < ROM_BASE + 4 * ROM_WORDS) begin
      if (req.we) begin
        rsp.err = 1'b1;
      end else begin
        rsp.rdata = ROM_IMAGE[(req.addr - ROM_BASE) >> 2];
      end
    end else if (req.addr >= SRAM_BASE && req.addr < SRAM_BASE + 4 * SRAM_WORDS) begin
      idx = (req.addr - SRAM_BASE) >> 2;
      if (req.we) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (req.be[b]) begin
            ref_sram[idx][8*b +: 8] = req.wdata[8*b +: 8];
          end
        end
      end else begin
        rsp.rdata = ref_sram[idx];
      end
    end else begin
      rsp.err = 1'b1;
    end
    return rsp;
  endfunction

  // drives one strobe from a falling edge to the next
  task automatic issue(input logic [ADDR_W-1:0] addr, input logic we,
                       input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] be);
    bus_req_t req;
    exp_t     entry;
    req = '{addr: addr, we: we, wdata: wdata, be: be};
    entry.rsp = model_access(req);
    entry.due = cyc + 2;
    exp_q.push_back(entry);
    req_valid_i = 1'b1;
    req_i       = req;
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic finish_test(input string name, input int unsigned errs_before);
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    tests_done++;
    $display("test %s done, %0d errors", name, total_errors() - errs_before);
  endtask

  // ----------------------------------------------------------------------
  // response monitor
  // ----------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_ni && resp_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("unexpected response in cycle %0d with nothing outstanding", cyc);
        errors++;
      end else begin
        head = exp_q.pop_front();
        assert (cyc == head.due) else begin
          $display("response due in cycle %0d arrived in cycle %0d", head.due, cyc);
          errors++;
        end
        assert (resp_o.err === head.rsp.err) else begin
          $display("mismatch at %0t: resp_o.err expected %b, got %b",
                   $time, head.rsp.err, resp_o.err);
          errors++;
        end
        assert (resp_o.rdata === head.rsp.rdata) else begin
          $display("mismatch at %0t: resp_o.rdata expected %h, got %h",
                   $time, head.rsp.rdata, resp_o.rdata);
          errors++;
        end
      end
    end else if (rst_ni && exp_q.size() != 0 && exp_q[0].due == cyc) begin
      head = exp_q.pop_front();
      $display("no response in cycle %0d for an outstanding request", cyc);
      errors++;
    end
  end

  task automatic debug_test();
    int unsigned base;
    base = total_errors();
    for (int i = 0; i < DEBUG_HOLDOFF; i++) begin
      assert (debug_req_o === 1'b0) else begin
        $display("mismatch at %0t: debug_req_o expected 0, got %b", $time, debug_req_o);
        errors++;
      end
      @(negedge clk_i);
    end
    // walk all input combinations twice once the hold-off is over
    for (int k = 0; k < 8; k++) begin
      debug_req_i = k[0];
      debug_en_i  = k[1];
      @(posedge clk_i);
      assert (debug_req_o === (k[0] & k[1])) else begin
        $display("mismatch at %0t: debug_req_o expected %b, got %b",
                 $time, k[0] & k[1], debug_req_o);
        errors++;
      end
      @(negedge clk_i);
    end
    finish_test("debug_gate", base);
  endtask

  task automatic sram_test();
    int unsigned       idx [SRAM_TESTS];
    logic [ADDR_W-1:0] addr;
    logic [31:0]       data;
    logic [31:0]       be_r;
    int unsigned       base;
    // zero and walking ones, so word 0 aliases with any word that loses an index bit
    idx  = '{0, 1, 2, 4, 8, 16, 32, 64, 128, 255};
    base = total_errors();
    for (int i = 0; i < SRAM_TESTS; i++) begin
      addr = SRAM_BASE + ADDR_W'(4 * idx[i]);
      data = next_rand();
      issue(addr, 1'b1, data, 4'hf);
      data = next_rand();
      be_r = next_rand();
      issue(addr, 1'b1, data, be_r[7:4]);
      issue(addr, 1'b0, '0, '0);
    end
    // second pass reads every word after all writes
    for (int i = 0; i < SRAM_TESTS; i++) begin
      issue(SRAM_BASE + ADDR_W'(4 * idx[i]), 1'b0, '0, '0);
    end
    finish_test("sram_rw", base);
  endtask

  initial begin
    int unsigned base;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    debug_req_i = 1'b1;
    debug_en_i  = 1'b1;
    errors      = 0;
    tests_done  = 0;
    lcg_state   = 32'd90314;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    debug_test();

    base = total_errors();
    for (int i = 0; i < ROM_WORDS; i++) begin
      issue(ROM_BASE + ADDR_W'(4 * i), 1'b0, '0, '0);
    end
    finish_test("rom_reads", base);

    sram_test();

    base = total_errors();
    issue(32'h0000_0000, 1'b0, '0, '0);
    issue(ROM_BASE + ADDR_W'(4 * ROM_WORDS), 1'b0, '0, '0);
    issue(SRAM_BASE + ADDR_W'(4 * SRAM_WORDS), 1'b0, '0, '0);
    issue(32'h4000_0000, 1'b0, '0, '0);
    issue(ROM_BASE, 1'b1, 32'h1111_2222, 4'hf);
    issue(ROM_BASE + 32'h3c, 1'b1, 32'h3333_4444, 4'h3);
    finish_test("error_resp", base);

    // mixed targets on consecutive cycles
    base = total_errors();
    issue(ROM_BASE + 32'h0c, 1'b0, '0, '0);
    issue(SRAM_BASE + 32'h28, 1'b1, next_rand(), 4'hf);
    issue(SRAM_BASE + 32'h28, 1'b0, '0, '0);
    issue(32'h2000_0010, 1'b0, '0, '0);
    issue(ROM_BASE + 32'h3c, 1'b0, '0, '0);
    issue(SRAM_BASE, 1'b0, '0, '0);
    issue(ROM_BASE + 32'h04, 1'b1, next_rand(), 4'hf);
    issue(SRAM_BASE + 32'h28, 1'b1, next_rand(), 4'h5);
    issue(SRAM_BASE + 32'h28, 1'b0, '0, '0);
    finish_test("back_to_back", base);

    $display("summary: %0d tests run, %0d errors", tests_done, total_errors());
    if (total_errors() == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog sized from the test lengths
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: tb/harness_properties.sv
/*
 * Harness property checker
 * Bound to the harness top level. Checks response latency, error data
 * and the debug hold-off window after reset.
 */
`timescale 1ns/1ps

module harness_properties import harness_pkg::*; #(
  parameter int unsigned DEBUG_HOLDOFF = 500
) (
  input logic     clk_i,
  input logic     rst_ni,
  input logic     req_valid_i,
  input logic     resp_valid_i,
  input bus_rsp_t resp_i,
  input logic     debug_out_i
);

  // cycles since reset, saturates at the hold-off length
  int unsigned cyc_q;
  int unsigned prop_errors;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc_q <= 0;
    end else if (cyc_q < DEBUG_HOLDOFF) begin
      cyc_q <= cyc_q + 1;
    end
  end

  a_resp_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |-> ##2 resp_valid_i)
    else begin
      $error("request not answered two cycles later");
      prop_errors++;
    end

  a_no_stray_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_i |-> $past(req_valid_i, 2))
    else begin
      $error("response without a request two cycles before");
      prop_errors++;
    end

  a_err_zero_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (resp_valid_i && resp_i.err) |-> (resp_i.rdata == '0))
    else begin
      $error("error response carries nonzero data");
      prop_errors++;
    end

  a_debug_holdoff: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cyc_q < DEBUG_HOLDOFF) |-> !debug_out_i)
    else begin
      $error("debug request passed during the hold-off window");
      prop_errors++;
    end

endmodule

bind harness_top harness_properties #(
  .DEBUG_HOLDOFF ( DEBUG_HOLDOFF )
) i_harness_properties (
  .clk_i        ( clk_i        ),
  .rst_ni       ( rst_ni       ),
  .req_valid_i  ( req_valid_i  ),
  .resp_valid_i ( resp_valid_o ),
  .resp_i       ( resp_o       ),
  .debug_out_i  ( debug_req_o  )
);

// File: rtl/harness_top.sv
/*
 * Harness top level
 * Address decode, boot ROM, SRAM and the in-order response stage,
 * plus the hold-off gate on the incoming debug request.
 */
`timescale 1ns/1ps

module harness_top import harness_pkg::*; #(
  parameter int unsigned SRAM_WORDS    = 256,
  parameter int unsigned DEBUG_HOLDOFF = 500
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_valid_i,
  input  bus_req_t req_i,
  output logic     resp_valid_o,
  output bus_rsp_t resp_o,
  input  logic     debug_req_i,
  input  logic     debug_en_i,
  output logic     debug_req_o
);

  logic              dec_valid;
  dec_req_t          dec;
  logic              rom_rd_en;
  logic              sram_en;
  logic [DATA_W-1:0] rom_rdata;
  logic [DATA_W-1:0] sram_rdata;

  // ------------------------------------------------------------------
  // request side
  // ------------------------------------------------------------------
  addr_decode #(
    .SRAM_WORDS ( SRAM_WORDS )
  ) i_addr_decode (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .dec_valid_o ( dec_valid   ),
    .dec_o       ( dec         )
  );

  // each memory only sees its own accesses
  assign rom_rd_en = dec_valid && (dec.target == TGT_ROM);
  assign sram_en   = dec_valid && (dec.target == TGT_SRAM);

  // ------------------------------------------------------------------
  // memories
  // ------------------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i      ( clk_i        ),
    .rd_en_i    ( rom_rd_en    ),
    .word_idx_i ( dec.word_idx ),
    .rdata_o    ( rom_rdata    )
  );

  sram_bank #(
    .SRAM_WORDS ( SRAM_WORDS )
  ) i_sram_bank (
    .clk_i      ( clk_i        ),
    .en_i       ( sram_en      ),
    .we_i       ( dec.we       ),
    .word_idx_i ( dec.word_idx ),
    .wdata_i    ( dec.wdata    ),
    .be_i       ( dec.be       ),
    .rdata_o    ( sram_rdata   )
  );

  // ------------------------------------------------------------------
  // response side and debug
  // ------------------------------------------------------------------
  resp_mux i_resp_mux (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .dec_valid_i  ( dec_valid    ),
    .dec_i        ( dec          ),
    .rom_rdata_i  ( rom_rdata    ),
    .sram_rdata_i ( sram_rdata   ),
    .resp_valid_o ( resp_valid_o ),
    .resp_o       ( resp_o       )
  );

  debug_gate #(
    .DEBUG_HOLDOFF ( DEBUG_HOLDOFF )
  ) i_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: rtl/debug_gate.sv
/*
 * Debug request gate
 * Holds off debug requests after reset and blocks them when disabled.
 */
`timescale 1ns/1ps

module debug_gate #(
  parameter int unsigned DEBUG_HOLDOFF = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  localparam int unsigned CNT_W = (DEBUG_HOLDOFF > 0) ? $clog2(DEBUG_HOLDOFF + 1) : 1;

  logic [CNT_W-1:0] cnt_q;
  logic             holdoff_done;

  // gives boot code time to run before the first halt
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CNT_W'(DEBUG_HOLDOFF);
    end else if (!holdoff_done) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign holdoff_done = (cnt_q == '0);
  assign debug_req_o  = holdoff_done & debug_en_i & debug_req_i;

endmodule

// File: rtl/resp_mux.sv
/*
 * Response stage
 * Tracks the target of each access for one cycle, then picks the
 * response from the memory outputs or the error responder.
 */
`timescale 1ns/1ps

module resp_mux import harness_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              dec_valid_i,
  input  dec_req_t          dec_i,
  input  logic [DATA_W-1:0] rom_rdata_i,
  input  logic [DATA_W-1:0] sram_rdata_i,
  output logic              resp_valid_o,
  output bus_rsp_t          resp_o
);

  logic    valid_q;
  target_e target_q;
  logic    we_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      target_q <= dec_i.target;
      we_q     <= dec_i.we;
    end
  end

  // memory data lands in the same cycle as the tracked target
  always_comb begin
    resp_o.rdata = '0;
    resp_o.err   = 1'b0;
    case (target_q)
      TGT_ROM: begin
        resp_o.rdata = rom_rdata_i;
      end
      TGT_SRAM: begin
        // writes answer with zero data
        resp_o.rdata = we_q ? '0 : sram_rdata_i;
      end
      default: begin
        resp_o.err = 1'b1;
      end
    endcase
  end

  assign resp_valid_o = valid_q;

endmodule

// File: mem/sram_bank.sv
/*
 * SRAM bank
 * Word array with byte-enabled writes and a registered read port.
 */
`timescale 1ns/1ps

module sram_bank import harness_pkg::*; #(
  parameter int unsigned SRAM_WORDS = 256
) (
  input  logic                  clk_i,
  input  logic                  en_i,
  input  logic                  we_i,
  input  logic [WORD_IDX_W-1:0] word_idx_i,
  input  logic [DATA_W-1:0]     wdata_i,
  input  logic [STRB_W-1:0]     be_i,
  output logic [DATA_W-1:0]     rdata_o
);

  localparam int unsigned SRAM_AW = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

  logic [DATA_W-1:0]  mem_q [SRAM_WORDS];
  logic [SRAM_AW-1:0] mem_addr;
  logic [DATA_W-1:0]  rdata_q;

  assign mem_addr = word_idx_i[SRAM_AW-1:0];

  // ------------------------------------------------------------------
  // write merges enabled bytes, read registers the whole word
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        for (int unsigned b = 0; b < STRB_W; b++) begin
          if (be_i[b]) begin
            mem_q[mem_addr][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[mem_addr];
      end
    end
  end

  // held between reads, resp_mux only samples it after a read
  assign rdata_o = rdata_q;

endmodule

// File: mem/boot_rom.sv
/*
 * Boot ROM
 * Fixed image from the harness package with a registered read port.
 */
`timescale 1ns/1ps

module boot_rom import harness_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rd_en_i,
  input  logic [WORD_IDX_W-1:0] word_idx_i,
  output logic [DATA_W-1:0]     rdata_o
);

  localparam int unsigned ROM_AW = $clog2(ROM_WORDS);

  logic [ROM_AW-1:0] rom_addr;
  logic [DATA_W-1:0] rdata_q;

  // decoder keeps the index inside the image
  assign rom_addr = word_idx_i[ROM_AW-1:0];

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rdata_q <= ROM_IMAGE[rom_addr];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: rtl/addr_decode.sv
/*
 * Address decoder
 * Registers each strobed request together with its target and word
 * index. Writes into the ROM window are sent to the error responder.
 */
`timescale 1ns/1ps

module addr_decode import harness_pkg::*; #(
  parameter int unsigned SRAM_WORDS = 256
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_valid_i,
  input  bus_req_t req_i,
  output logic     dec_valid_o,
  output dec_req_t dec_o
);

  // window sizes in bytes
  localparam logic [ADDR_W-1:0] ROM_SPAN  = ADDR_W'(4 * ROM_WORDS);
  localparam logic [ADDR_W-1:0] SRAM_SPAN = ADDR_W'(4 * SRAM_WORDS);

  logic [ADDR_W-1:0] rom_off;
  logic [ADDR_W-1:0] sram_off;
  logic              rom_hit;
  logic              sram_hit;
  dec_req_t          dec_d;
  logic              dec_valid_q;
  dec_req_t          dec_q;

  // offsets wrap below the base, so one compare covers both bounds
  assign rom_off  = req_i.addr - ROM_BASE;
  assign sram_off = req_i.addr - SRAM_BASE;
  assign rom_hit  = rom_off < ROM_SPAN;
  assign sram_hit = sram_off < SRAM_SPAN;

  always_comb begin
    dec_d          = '0;
    dec_d.we       = req_i.we;
    dec_d.wdata    = req_i.wdata;
    dec_d.be       = req_i.be;
    dec_d.target   = TGT_ERR;
    if (rom_hit && !req_i.we) begin
      dec_d.target   = TGT_ROM;
      dec_d.word_idx = rom_off[WORD_IDX_W+1:2];
    end else if (sram_hit) begin
      dec_d.target   = TGT_SRAM;
      dec_d.word_idx = sram_off[WORD_IDX_W+1:2];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_q <= 1'b0;
    end else begin
      dec_valid_q <= req_valid_i;
    end
  end

  // payload only, qualified by dec_valid_q
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      dec_q <= dec_d;
    end
  end

  assign dec_valid_o = dec_valid_q;
  assign dec_o       = dec_q;

endmodule

// File: common/harness_pkg.sv
/*
 * Harness package
 * Shared bus widths, the address map, the boot ROM image and the
 * request, decoded-request and response types of the memory harness.
 */
package harness_pkg;

  // bus widths
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned STRB_W     = DATA_W / 8;
  localparam int unsigned WORD_IDX_W = 16;

  // ------------------------------------------------------------------
  // address map
  // ------------------------------------------------------------------
  localparam logic [ADDR_W-1:0] ROM_BASE  = 32'h0001_0000;
  localparam int unsigned       ROM_WORDS = 16;
  localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;

  // small boot stub, jumps to the SRAM base
  localparam logic [DATA_W-1:0] ROM_IMAGE [ROM_WORDS] = '{
    32'h0000_0297, 32'h0202_8593, 32'hf140_2573, 32'h0182_b283,
    32'h0002_8067, 32'h0000_0000, 32'h8000_0000, 32'h0000_0000,
    32'hedfe_0dd0, 32'h1234_5678, 32'h9abc_def0, 32'h0f1e_2d3c,
    32'h4b5a_6978, 32'hdead_beef, 32'hcafe_f00d, 32'h1050_0073
  };

  // ------------------------------------------------------------------
  // bus types
  // ------------------------------------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] be;
  } bus_req_t;

  typedef enum logic [1:0] {
    TGT_ROM  = 2'd0,
    TGT_SRAM = 2'd1,
    TGT_ERR  = 2'd2
  } target_e;

  typedef struct packed {
    target_e               target;
    logic [WORD_IDX_W-1:0] word_idx;
    logic                  we;
    logic [DATA_W-1:0]     wdata;
    logic [STRB_W-1:0]     be;
  } dec_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } bus_rsp_t;

endpackage
